// ==== filelist.f ====
+incdir+test
rtl/aurora_pkg.sv
rtl/tx_stream_if.sv
rtl/pulse_delay.sv
rtl/adc_pkt_sender.sv
rtl/eds_pkt_repacker.sv
rtl/pop_clr_gen.sv
rtl/tx_stream_mux.sv
rtl/aurora_inf_top.sv
test/tb_aurora_inf_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and pass only if the log holds the pass line.
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_aurora_inf_top -f filelist.f -o tb_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

grep -qx "Simulation passed" sim.log && echo "run ok" \
    || { echo "run failed, see sim.log"; exit 1; }

// ==== test/tb_tasks.svh ====
// ----------------------------------------------------------------------
// checkers and common steps
// ----------------------------------------------------------------------
task automatic check_val(input string name, input logic [127:0] exp, input logic [127:0] got);
    chk_cnt++;
    assert (exp === got) else begin
        err_cnt++;
        $display("FAIL %s: expected %h, got %h", name, exp, got);
    end
endtask

task automatic check_true(input logic cond, input string msg);
    chk_cnt++;
    assert (cond === 1'b1) else begin
        err_cnt++;
        $display("ERROR: %s", msg);
    end
endtask

task automatic next_cycle();
    @(posedge user_clk);
    #DRIVE_DLY;
endtask

task automatic wait_cycles(input int n);
    repeat (n) next_cycle();
endtask

task automatic clear_expect();
    exp_data_q.delete();
    exp_keep_q.delete();
    exp_last_q.delete();
    got_data_q.delete();
    got_keep_q.delete();
    got_last_q.delete();
endtask

task automatic push_exp(input tx_data_t d, input tx_keep_t k, input logic l);
    exp_data_q.push_back(d);
    exp_keep_q.push_back(k);
    exp_last_q.push_back(l);
endtask

task automatic compare_got(input string name);
    int i;
    check_val({name, " word count"}, exp_data_q.size(), got_data_q.size());
    for (i = 0; i < exp_data_q.size() && i < got_data_q.size(); i++) begin
        check_val($sformatf("%s data %0d", name, i), exp_data_q[i], got_data_q[i]);
        check_val($sformatf("%s keep %0d", name, i), exp_keep_q[i], got_keep_q[i]);
        check_val($sformatf("%s last %0d", name, i), exp_last_q[i], got_last_q[i]);
    end
endtask

// optional random tx_tready while waiting
task automatic wait_words(input int n, input int limit, input bit stall, input string name);
    int i;
    int rnd;
    i = 0;
    while (got_data_q.size() < n && i < limit) begin
        next_cycle();
        if (stall) begin
            rnd       = $random(seed);
            tx_tready = rnd[0];
        end
        i++;
    end
    check_true(got_data_q.size() >= n, {name, ": timeout waiting for transmit words"});
endtask

task automatic load_adc(input int npkt);
    int       p;
    int       w;
    head_t    h;
    tx_data_t d;
    for (p = 0; p < npkt; p++) begin
        h = 64'hA5A5_0000_0000_0000 | 64'(p + 1);
        head_q.push_back(h);
        push_exp({h, 64'h0}, '1, 1'b0);              // header beat, lower half zero
        for (w = 0; w < ADC_PKT_WORDS; w++) begin
            d = {4{32'hADC0_0000 + 32'(p * ADC_PKT_WORDS + w)}};
            adc_q.push_back(d);
            push_exp(d, '1, w == ADC_PKT_WORDS - 1);
        end
    end
    refresh_fifo();
endtask

// ----------------------------------------------------------------------
// directed tests
// ----------------------------------------------------------------------
task automatic reset_idle();
    int i;
    rst_n = 1'b0;
    for (i = 0; i < 2; i++) begin
        next_cycle();
        check_val("reset_idle in reset", 6'b0,
                  {tx_tvalid, head_rd, adc_fifo_rd, eds_cpl, pop_end_pkt, eds_clr_buff});
    end
    rst_n = 1'b1;
    for (i = 0; i < 4; i++) begin
        @(negedge user_clk);
        check_val("reset_idle after reset", 6'b0,
                  {tx_tvalid, head_rd, adc_fifo_rd, eds_cpl, pop_end_pkt, eds_clr_buff});
    end
endtask

task automatic adc_packet();
    next_cycle();
    clear_expect();
    tx_tready = 1'b1;
    load_adc(2);
    wait_words(2 * (ADC_PKT_WORDS + 1), 200, 1'b0, "adc_packet");
    wait_cycles(3);                                   // nothing extra may follow
    compare_got("adc_packet");
    check_true(head_q.size() == 0 && adc_q.size() == 0, "adc_packet: FIFOs not empty at end");
endtask

task automatic eds_repack();
    rx_data_t w [7];
    int       i;
    int       start_cpl;
    int       d;
    int       h;
    next_cycle();
    clear_expect();
    tx_tready = 1'b1;
    start_cpl = eds_cpl_cnt;
    for (i = 0; i < 7; i++) begin
        w[i] = 64'hED50_0000_0000_0000 + 64'(i);
    end
    push_exp({w[0], w[1]}, '1, 1'b0);
    push_exp({w[2], w[3]}, '1, 1'b1);
    push_exp({w[4], w[5]}, '1, 1'b0);
    push_exp({w[6], 64'h0}, 16'hFF00, 1'b1);         // odd tail padded
    for (i = 0; i < 7; i++) begin
        rx_tvalid = 1'b1;
        rx_tdata  = w[i];
        rx_tkeep  = 8'hFF;
        rx_tlast  = (i == 3) || (i == 6);             // 4-word then 3-word packet
        next_cycle();
    end
    rx_tvalid = 1'b0;
    rx_tlast  = 1'b0;
    d = 0;
    while (!eds_cpl && d < 100) begin
        @(negedge user_clk);
        d++;
    end
    check_true(eds_cpl, "eds_repack: eds_cpl never pulsed");
    d = 0;
    while (!eds_clr_buff && d < 100) begin
        @(negedge user_clk);
        d++;
    end
    check_val("eds_repack clr delay", CLR_DELAY + 1, d);
    h = 0;
    while (eds_clr_buff && h < 100) begin
        @(negedge user_clk);
        h++;
    end
    check_val("eds_repack clr hold", CLR_HOLD, h);
    wait_words(4, 50, 1'b0, "eds_repack");
    wait_cycles(3);
    compare_got("eds_repack");
    check_val("eds_repack eds_cpl pulses", start_cpl + 2, eds_cpl_cnt);
endtask

task automatic backpressure();
    next_cycle();
    clear_expect();
    load_adc(2);                                      // same words as adc_packet
    wait_words(2 * (ADC_PKT_WORDS + 1), 400, 1'b1, "backpressure");
    tx_tready = 1'b1;
    wait_cycles(3);
    compare_got("backpressure");
    check_true(head_q.size() == 0 && adc_q.size() == 0, "backpressure: FIFOs not empty at end");
endtask

task automatic end_packet();
    int start_pop;
    int d;
    next_cycle();
    clear_expect();
    tx_tready = 1'b1;
    start_pop = pop_end_cnt;
    push_exp(POP_END_WORD, '1, 1'b1);
    ena_cpl = 1'b1;                                   // EDS flag is left from eds_repack
    adc_cpl = 1'b1;
    cfg_cpl = 1'b1;
    next_cycle();
    ena_cpl = 1'b0;
    adc_cpl = 1'b0;
    cfg_cpl = 1'b0;
    wait_words(1, 50, 1'b0, "end_packet");
    wait_cycles(3);
    compare_got("end_packet");
    check_val("end_packet pop_end_pkt pulses", start_pop + 1, pop_end_cnt);

    // cfg_rst drops the collected flags before the set is complete
    rx_tvalid = 1'b1;                                 // one-word EDS packet sets the EDS flag
    rx_tdata  = 64'hED50_0000_0000_0100;
    rx_tkeep  = 8'hFF;
    rx_tlast  = 1'b1;
    next_cycle();
    rx_tvalid = 1'b0;
    rx_tlast  = 1'b0;
    d = 0;
    while (!eds_cpl && d < 50) begin
        @(negedge user_clk);
        d++;
    end
    check_true(eds_cpl, "end_packet: eds_cpl never pulsed");
    next_cycle();
    clear_expect();
    start_pop = pop_end_cnt;
    ena_cpl   = 1'b1;
    adc_cpl   = 1'b1;
    next_cycle();
    ena_cpl = 1'b0;
    adc_cpl = 1'b0;
    cfg_rst = 1'b1;
    next_cycle();
    cfg_rst = 1'b0;
    wait_cycles(6);
    cfg_cpl = 1'b1;
    next_cycle();
    cfg_cpl = 1'b0;
    wait_cycles(20);
    check_val("end_packet after cfg_rst words", 0, got_data_q.size());
    check_val("end_packet after cfg_rst pulses", start_pop, pop_end_cnt);
endtask

// ==== test/tb_aurora_inf_top.sv ====
module tb_aurora_inf_top;
    import aurora_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DLY  = 10;        // input skew after the rising edge
    localparam int CLR_DELAY  = 20;
    localparam int CLR_HOLD   = 5;

    logic     user_clk;
    logic     rst_n;
    logic     cfg_rst;
    tx_data_t adc_fifo_din;
    logic     adc_fifo_empty;
    adc_cnt_t adc_fifo_data_cnt;
    head_t    head_din;
    logic     adc_fifo_rd;
    logic     head_rd;
    rx_data_t rx_tdata;
    rx_keep_t rx_tkeep;
    logic     rx_tvalid;
    logic     rx_tlast;
    tx_data_t tx_tdata;
    tx_keep_t tx_tkeep;
    logic     tx_tvalid;
    logic     tx_tlast;
    logic     tx_tready;
    logic     ena_cpl;
    logic     adc_cpl;
    logic     cfg_cpl;
    logic     eds_cpl;
    logic     pop_end_pkt;
    logic     eds_clr_buff;

    head_t    head_q[$];                   // header FIFO contents, front is shown
    tx_data_t adc_q[$];
    logic     pop_head;                    // pops seen before the coming edge
    logic     pop_adc;

    tx_data_t exp_data_q[$];
    tx_keep_t exp_keep_q[$];
    logic     exp_last_q[$];
    tx_data_t got_data_q[$];               // every word that left on the link
    tx_keep_t got_keep_q[$];
    logic     got_last_q[$];

    int       eds_cpl_cnt;
    int       pop_end_cnt;
    int       err_cnt;
    int       chk_cnt;
    int       seed;

    `include "tb_tasks.svh"

    aurora_inf_top #(
        .CLR_DELAY(CLR_DELAY),
        .CLR_HOLD (CLR_HOLD)
    ) dut0 (
        .user_clk(user_clk), .rst_n(rst_n), .cfg_rst(cfg_rst),
        .adc_fifo_din(adc_fifo_din), .adc_fifo_empty(adc_fifo_empty),
        .adc_fifo_data_cnt(adc_fifo_data_cnt), .head_din(head_din),
        .adc_fifo_rd(adc_fifo_rd), .head_rd(head_rd),
        .rx_tdata(rx_tdata), .rx_tkeep(rx_tkeep), .rx_tvalid(rx_tvalid),
        .rx_tlast(rx_tlast), .tx_tdata(tx_tdata), .tx_tkeep(tx_tkeep),
        .tx_tvalid(tx_tvalid), .tx_tlast(tx_tlast), .tx_tready(tx_tready),
        .ena_cpl(ena_cpl), .adc_cpl(adc_cpl), .cfg_cpl(cfg_cpl),
        .eds_cpl(eds_cpl), .pop_end_pkt(pop_end_pkt), .eds_clr_buff(eds_clr_buff)
    );

    initial begin
        user_clk = 1'b0;
        forever #(CLK_PERIOD / 2) user_clk = ~user_clk;
    end

    // ----------------------------------------------------------------------
    // show-ahead FIFO models and link monitor
    // ----------------------------------------------------------------------
    task automatic refresh_fifo();
        head_din          = (head_q.size() != 0) ? head_q[0] : '0;
        adc_fifo_din      = (adc_q.size() != 0) ? adc_q[0] : '0;
        adc_fifo_empty    = (adc_q.size() == 0);
        adc_fifo_data_cnt = adc_cnt_t'(adc_q.size());
    endtask

    always @(negedge user_clk) begin
        pop_head = head_rd;                // outputs are settled mid-cycle
        pop_adc  = adc_fifo_rd;
        if (tx_tvalid && tx_tready) begin
            got_data_q.push_back(tx_tdata);
            got_keep_q.push_back(tx_tkeep);
            got_last_q.push_back(tx_tlast);
        end
        if (eds_cpl) begin
            eds_cpl_cnt++;
        end
        if (pop_end_pkt) begin
            pop_end_cnt++;
        end
    end

    always @(posedge user_clk) begin
        #DRIVE_DLY;
        if (pop_head && head_q.size() != 0) begin
            void'(head_q.pop_front());
        end
        if (pop_adc && adc_q.size() != 0) begin
            void'(adc_q.pop_front());
        end
        refresh_fifo();
    end

    initial begin
        seed        = 32'h001f_ffd4;
        err_cnt     = 0;
        chk_cnt     = 0;
        eds_cpl_cnt = 0;
        pop_end_cnt = 0;
        pop_head    = 1'b0;
        pop_adc     = 1'b0;
        rst_n       = 1'b0;
        cfg_rst     = 1'b0;
        rx_tdata    = '0;
        rx_tkeep    = '0;
        rx_tvalid   = 1'b0;
        rx_tlast    = 1'b0;
        tx_tready   = 1'b1;
        ena_cpl     = 1'b0;
        adc_cpl     = 1'b0;
        cfg_cpl     = 1'b0;
        refresh_fifo();

        reset_idle();
        adc_packet();
        eds_repack();
        backpressure();
        end_packet();

        $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== rtl/aurora_inf_top.sv ====
module aurora_inf_top #(
    parameter int CLR_DELAY = 15000000,
    parameter int CLR_HOLD  = 40
) (
    input  logic                 user_clk,
    input  logic                 rst_n,
    input  logic                 cfg_rst,
    // ADC and header FIFOs, show-ahead
    input  aurora_pkg::tx_data_t adc_fifo_din,
    input  logic                 adc_fifo_empty,
    input  aurora_pkg::adc_cnt_t adc_fifo_data_cnt,
    input  aurora_pkg::head_t    head_din,
    output logic                 adc_fifo_rd,
    output logic                 head_rd,
    // receive stream carrying EDS packets
    input  aurora_pkg::rx_data_t rx_tdata,
    input  aurora_pkg::rx_keep_t rx_tkeep,
    input  logic                 rx_tvalid,
    input  logic                 rx_tlast,
    // transmit stream
    output aurora_pkg::tx_data_t tx_tdata,
    output aurora_pkg::tx_keep_t tx_tkeep,
    output logic                 tx_tvalid,
    output logic                 tx_tlast,
    input  logic                 tx_tready,
    // completion events
    input  logic                 ena_cpl,
    input  logic                 adc_cpl,
    input  logic                 cfg_cpl,
    output logic                 eds_cpl,
    output logic                 pop_end_pkt,
    output logic                 eds_clr_buff
);
    import aurora_pkg::*;

    logic [3:0] cfg_rst_sr;     // four-stage delay line
    logic       cfg_rst_d4;
    logic       eds_send_en;
    logic       pop_en;
    adc_cnt_t   adc_cnt_ready;

    tx_stream_if adc_s ();
    tx_stream_if eds_s ();
    tx_stream_if pop_s ();

    // ----------------------------------------------------------------------
    // configuration reset, delayed by four cycles
    // ----------------------------------------------------------------------
    always_ff @(posedge user_clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_rst_sr <= '0;
        end else begin
            cfg_rst_sr <= {cfg_rst_sr[2:0], cfg_rst};
        end
    end

    assign cfg_rst_d4    = cfg_rst_sr[3];
    assign adc_cnt_ready = adc_fifo_empty ? '0 : adc_fifo_data_cnt;  // empty means no data

    adc_pkt_sender u_adc_pkt_sender (
        .user_clk(user_clk), .rst_n(rst_n), .cfg_rst(cfg_rst_d4),
        .adc_fifo_din(adc_fifo_din), .adc_fifo_data_cnt(adc_cnt_ready),
        .head_din(head_din), .adc_fifo_rd(adc_fifo_rd), .head_rd(head_rd),
        .m(adc_s.src)
    );

    eds_pkt_repacker u_eds_pkt_repacker (
        .user_clk(user_clk), .rst_n(rst_n), .cfg_rst(cfg_rst_d4),
        .rx_tdata(rx_tdata), .rx_tkeep(rx_tkeep), .rx_tvalid(rx_tvalid),
        .rx_tlast(rx_tlast), .eds_send_en(eds_send_en), .eds_cpl(eds_cpl),
        .m(eds_s.src)
    );

    pop_clr_gen u_pop_clr_gen (
        .user_clk(user_clk), .rst_n(rst_n), .cfg_rst(cfg_rst_d4),
        .ena_cpl(ena_cpl), .eds_cpl(eds_cpl), .adc_cpl(adc_cpl), .cfg_cpl(cfg_cpl),
        .pop_en(pop_en), .pop_end_pkt(pop_end_pkt), .m(pop_s.src)
    );

    tx_stream_mux u_tx_stream_mux (
        .user_clk(user_clk), .rst_n(rst_n), .eds_send_en(eds_send_en),
        .pop_en(pop_en), .tx_tready(tx_tready),
        .adc_s(adc_s.snk), .eds_s(eds_s.snk), .pop_s(pop_s.snk),
        .tx_tdata(tx_tdata), .tx_tkeep(tx_tkeep), .tx_tvalid(tx_tvalid),
        .tx_tlast(tx_tlast)
    );

    // buffer clear request, long after each EDS packet
    pulse_delay #(
        .DELAY(CLR_DELAY),
        .HOLD (CLR_HOLD)
    ) u_eds_clr_delay (
        .user_clk(user_clk), .rst_n(rst_n), .sig(eds_cpl), .pulse(eds_clr_buff)
    );

endmodule

// ==== rtl/tx_stream_mux.sv ====
module tx_stream_mux (
    input  logic                 user_clk,
    input  logic                 rst_n,
    input  logic                 eds_send_en,
    input  logic                 pop_en,
    input  logic                 tx_tready,
    tx_stream_if.snk             adc_s,
    tx_stream_if.snk             eds_s,
    tx_stream_if.snk             pop_s,
    output aurora_pkg::tx_data_t tx_tdata,
    output aurora_pkg::tx_keep_t tx_tkeep,
    output logic                 tx_tvalid,
    output logic                 tx_tlast
);

    logic adc_sel_d1;
    logic adc_sel;     // ADC owns the link while no EDS packet waits

    always_ff @(posedge user_clk or negedge rst_n) begin
        if (!rst_n) begin
            adc_sel_d1 <= 1'b0;
            adc_sel    <= 1'b0;
        end else begin
            adc_sel_d1 <= ~eds_send_en;
            adc_sel    <= adc_sel_d1;
        end
    end

    // ----------------------------------------------------------------------
    // source select, end-of-run first
    // ----------------------------------------------------------------------
    always_comb begin
        if (pop_en) begin
            tx_tdata  = pop_s.tdata;
            tx_tkeep  = pop_s.tkeep;
            tx_tvalid = pop_s.tvalid;
            tx_tlast  = pop_s.tlast;
        end else if (adc_sel) begin
            tx_tdata  = adc_s.tdata;
            tx_tkeep  = adc_s.tkeep;
            tx_tvalid = adc_s.tvalid;
            tx_tlast  = adc_s.tlast;
        end else begin
            tx_tdata  = eds_s.tdata;
            tx_tkeep  = eds_s.tkeep;
            tx_tvalid = eds_s.tvalid;
            tx_tlast  = eds_s.tlast;
        end
    end

    assign pop_s.tready = pop_en & tx_tready;
    assign adc_s.tready = ~pop_en & adc_sel & tx_tready;
    assign eds_s.tready = ~pop_en & ~adc_sel & tx_tready;   // unselected sources stall

endmodule

// ==== rtl/pop_clr_gen.sv ====
module pop_clr_gen (
    input  logic     user_clk,
    input  logic     rst_n,
    input  logic     cfg_rst,
    input  logic     ena_cpl,
    input  logic     eds_cpl,
    input  logic     adc_cpl,
    input  logic     cfg_cpl,
    output logic     pop_en,
    output logic     pop_end_pkt,
    tx_stream_if.src m
);
    import aurora_pkg::*;

    logic [3:0] cpl_flags;    // sticky, one per completion source
    logic [3:0] cpl_pulse;
    logic       xfer;

    assign cpl_pulse = {cfg_cpl, adc_cpl, eds_cpl, ena_cpl};
    assign xfer      = m.tvalid & m.tready;

    // ----------------------------------------------------------------------
    // completion tracking and end-of-run request
    // ----------------------------------------------------------------------
    always_ff @(posedge user_clk or negedge rst_n) begin
        if (!rst_n) begin
            cpl_flags   <= '0;
            pop_en      <= 1'b0;
            pop_end_pkt <= 1'b0;
        end else if (cfg_rst) begin
            cpl_flags   <= '0;
            pop_en      <= 1'b0;
            pop_end_pkt <= 1'b0;
        end else begin
            // sent word clears the set, a fresh pulse still counts
            cpl_flags   <= (cpl_flags & {4{~xfer}}) | cpl_pulse;
            pop_end_pkt <= xfer;
            if (xfer) begin
                pop_en <= 1'b0;
            end else begin
                pop_en <= &cpl_flags;                    // one cycle after the last flag
            end
        end
    end

    // single-beat end packet
    assign m.tvalid = pop_en;
    assign m.tdata  = POP_END_WORD;
    assign m.tkeep  = '1;
    assign m.tlast  = 1'b1;

endmodule

// ==== rtl/eds_pkt_repacker.sv ====
module eds_pkt_repacker (
    input  logic                 user_clk,
    input  logic                 rst_n,
    input  logic                 cfg_rst,
    input  aurora_pkg::rx_data_t rx_tdata,
    input  aurora_pkg::rx_keep_t rx_tkeep,
    input  logic                 rx_tvalid,
    input  logic                 rx_tlast,
    output logic                 eds_send_en,
    output logic                 eds_cpl,
    tx_stream_if.src             m
);
    import aurora_pkg::*;

    localparam int AW = $clog2(EDS_FIFO_DEPTH);
    localparam int PW = $clog2(EDS_FIFO_DEPTH + 1);

    tx_data_t mem_data [EDS_FIFO_DEPTH];
    tx_keep_t mem_keep [EDS_FIFO_DEPTH];
    logic     mem_last [EDS_FIFO_DEPTH];

    logic [AW:0]   wr_ptr;
    logic [AW:0]   rd_ptr;
    logic [PW-1:0] pkt_cnt;     // complete packets held in the buffer
    rx_data_t      hi_data;     // first word of a pair
    rx_keep_t      hi_keep;
    logic          hi_vld;
    tx_data_t      wr_data;
    tx_keep_t      wr_keep;
    logic          wr_last;
    logic          wr_en;
    logic          wr_ok;
    logic          rd_en;
    logic          full;

    // ----------------------------------------------------------------------
    // pairing of 64-bit words, first word on top
    // ----------------------------------------------------------------------
    always_comb begin
        wr_en   = 1'b0;
        wr_data = {hi_data, rx_tdata};
        wr_keep = {hi_keep, rx_tkeep};
        wr_last = rx_tlast;
        if (rx_tvalid) begin
            if (hi_vld) begin
                wr_en = 1'b1;
            end else if (rx_tlast) begin
                wr_en   = 1'b1;                          // odd tail, pad lower half
                wr_data = {rx_tdata, 64'h0};
                wr_keep = {rx_tkeep, 8'h00};
            end
        end
    end

    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign wr_ok = wr_en & ~full;                        // word dropped when full
    assign rd_en = m.tvalid & m.tready;

    always_ff @(posedge user_clk) begin
        if (rx_tvalid && !hi_vld) begin
            hi_data <= rx_tdata;
            hi_keep <= rx_tkeep;
        end
        if (wr_ok) begin
            mem_data[wr_ptr[AW-1:0]] <= wr_data;
            mem_keep[wr_ptr[AW-1:0]] <= wr_keep;
            mem_last[wr_ptr[AW-1:0]] <= wr_last;
        end
    end

    always_ff @(posedge user_clk or negedge rst_n) begin
        if (!rst_n) begin
            hi_vld  <= 1'b0;
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            pkt_cnt <= '0;
            eds_cpl <= 1'b0;
        end else if (cfg_rst) begin
            hi_vld  <= 1'b0;
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            pkt_cnt <= '0;
            eds_cpl <= 1'b0;
        end else begin
            if (rx_tvalid) begin
                hi_vld <= !hi_vld && !rx_tlast;
            end
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_ok && wr_last, rd_en && m.tlast})
                2'b10:   pkt_cnt <= pkt_cnt + 1'b1;
                2'b01:   pkt_cnt <= pkt_cnt - 1'b1;
                default: pkt_cnt <= pkt_cnt;
            endcase
            eds_cpl <= rd_en && m.tlast;                 // one cycle after last beat
        end
    end

    // only whole packets are offered downstream
    assign eds_send_en = (pkt_cnt != '0);
    assign m.tvalid    = eds_send_en;
    assign m.tdata     = mem_data[rd_ptr[AW-1:0]];
    assign m.tkeep     = mem_keep[rd_ptr[AW-1:0]];
    assign m.tlast     = mem_last[rd_ptr[AW-1:0]];

endmodule

// ==== rtl/adc_pkt_sender.sv ====
module adc_pkt_sender (
    input  logic                 user_clk,
    input  logic                 rst_n,
    input  logic                 cfg_rst,
    input  aurora_pkg::tx_data_t adc_fifo_din,
    input  aurora_pkg::adc_cnt_t adc_fifo_data_cnt,
    input  aurora_pkg::head_t    head_din,
    output logic                 adc_fifo_rd,
    output logic                 head_rd,
    tx_stream_if.src             m
);
    import aurora_pkg::*;

    localparam int BW = (ADC_PKT_WORDS > 1) ? $clog2(ADC_PKT_WORDS) : 1;

    typedef enum logic [1:0] {
        S_IDLE,
        S_HEAD,
        S_DATA
    } adc_state_t;

    adc_state_t    state;
    logic [BW-1:0] beat_cnt;    // data beat index inside the packet
    logic          xfer;
    logic          last_beat;
    logic          pkt_ready;

    assign xfer      = m.tvalid & m.tready;
    assign last_beat = (beat_cnt == BW'(ADC_PKT_WORDS - 1));
    assign pkt_ready = (adc_fifo_data_cnt >= adc_cnt_t'(ADC_PKT_WORDS)); // whole packet queued

    // ----------------------------------------------------------------------
    // packet FSM
    // ----------------------------------------------------------------------
    always_ff @(posedge user_clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            beat_cnt <= '0;
        end else if (cfg_rst) begin
            state    <= S_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    beat_cnt <= '0;
                    if (pkt_ready) begin
                        state <= S_HEAD;
                    end
                end
                S_HEAD: begin
                    if (xfer) begin
                        state <= S_DATA;
                    end
                end
                S_DATA: begin
                    if (xfer) begin
                        if (last_beat) begin
                            state    <= S_IDLE;
                            beat_cnt <= '0;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // beat contents, held until transferred
    // ----------------------------------------------------------------------
    always_comb begin
        m.tvalid = (state != S_IDLE);
        m.tkeep  = '1;                                   // every beat is full width
        m.tlast  = (state == S_DATA) && last_beat;
        if (state == S_HEAD) begin
            m.tdata = {head_din, 64'h0};                 // header sits in upper half
        end else begin
            m.tdata = adc_fifo_din;                      // show-ahead FIFO output
        end
    end

    // pops happen with the transfer that consumed the word
    assign head_rd     = (state == S_HEAD) && xfer;
    assign adc_fifo_rd = (state == S_DATA) && xfer;

endmodule

// ==== rtl/pulse_delay.sv ====
module pulse_delay #(
    parameter int DELAY = 15000000,
    parameter int HOLD  = 40
) (
    input  logic user_clk,
    input  logic rst_n,
    input  logic sig,
    output logic pulse
);

    typedef enum logic [1:0] {
        PD_IDLE,
        PD_DELAY,
        PD_HOLD
    } pd_state_t;

    pd_state_t   state;
    logic        sig_d;
    logic        sig_rise;
    logic [31:0] cnt;        // shared by delay and hold phases

    assign sig_rise = sig & ~sig_d;

    always_ff @(posedge user_clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= PD_IDLE;
            sig_d <= 1'b0;
            cnt   <= '0;
        end else begin
            sig_d <= sig;
            case (state)
                PD_IDLE: begin
                    cnt <= '0;
                    if (sig_rise) begin
                        state <= PD_DELAY;                   // later edges ignored until idle
                    end
                end
                PD_DELAY: begin
                    if (cnt == 32'(DELAY - 1)) begin
                        state <= PD_HOLD;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                PD_HOLD: begin
                    if (cnt == 32'(HOLD - 1)) begin
                        state <= PD_IDLE;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    state <= PD_IDLE;
                end
            endcase
        end
    end

    assign pulse = (state == PD_HOLD);

endmodule

// ==== rtl/tx_stream_if.sv ====
interface tx_stream_if;
    import aurora_pkg::*;

    tx_data_t tdata;
    tx_keep_t tkeep;
    logic     tvalid;
    logic     tlast;
    logic     tready;    // only signal driven by the sink

    modport src (
        output tdata,
        output tkeep,
        output tvalid,
        output tlast,
        input  tready
    );

    modport snk (
        input  tdata,
        input  tkeep,
        input  tvalid,
        input  tlast,
        output tready
    );

endinterface

// ==== rtl/aurora_pkg.sv ====
package aurora_pkg;

    // ----------------------------------------------------------------------
    // word types of the transmit and receive streams
    // ----------------------------------------------------------------------
    typedef logic [127:0] tx_data_t;               // one 128-bit transmit beat
    typedef logic [15:0]  tx_keep_t;               // byte enables, msb = upper byte
    typedef logic [63:0]  rx_data_t;               // one 64-bit receive word
    typedef logic [7:0]   rx_keep_t;

    // ADC side
    typedef logic [63:0]  head_t;                  // packet header from header FIFO
    typedef logic [10:0]  adc_cnt_t;               // ADC FIFO fill level

    // ----------------------------------------------------------------------
    // fixed constants
    // ----------------------------------------------------------------------
    localparam int ADC_PKT_WORDS = 4;              // data beats after each header

    // end-of-run marker word
    localparam tx_data_t POP_END_WORD = 128'hEEEE_0000_DDDD_0000_CCCC_0000_E0D0_5A5A;

    localparam int EDS_FIFO_DEPTH = 16;            // 128-bit entries in EDS buffer

endpackage
